// ==== Makefile ====
TOP = clockDisplayTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f clockDisplay.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f clockDisplay.f -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== clockDisplay.f ====
src/clockDisplayPkg.sv
src/vgaTiming.sv
src/displayRegisterFile.sv
src/bcdConverter.sv
src/digitPointerBank.sv
src/glyphAddressGenerator.sv
src/clockDisplay.sv
verif/clockDisplayChk.sv
verif/clockDisplayTb.sv

// ==== src/bcdConverter.sv ====
module bcdConverter (
	input logic [6:0] value,
	output logic [3:0] tens,
	output logic [3:0] units
);

	// Tens and units nibbles above the binary input
	logic [14:0] work;

	// Double dabble, the hundreds digit shifts out and is lost
	always_comb
	begin
		work = {8'd0, value};
		for (int i = 0; i < 7; i++)
		begin
			if (work[10:7] >= 4'd5)
				work[10:7] = work[10:7] + 4'd3;
			if (work[14:11] >= 4'd5)
				work[14:11] = work[14:11] + 4'd3;
			work = work << 1;
		end
	end

	assign tens = work[14:11];
	assign units = work[10:7];

endmodule

// ==== src/clockDisplay.sv ====
module clockDisplay (
	input logic CLK,
	input logic RESET,
	input logic wrEnable,
	input logic [clockDisplayPkg::fieldAddrWidth-1:0] wrAddr,
	input logic [clockDisplayPkg::fieldWidth-1:0] wrData,
	output logic [1:0] romSelect,
	output logic [18:0] romAddr,
	output logic hSync,
	output logic vSync
);

	logic [9:0] posX;
	logic [9:0] posY;
	logic rawHSync;
	logic rawVSync;
	logic blankStart;
	logic [clockDisplayPkg::fieldAddrWidth-1:0] rdAddr;
	logic [clockDisplayPkg::fieldWidth-1:0] rdData;
	logic [clockDisplayPkg::digitCount-1:0][3:0] digitCodes;
	logic ringFlag;
	logic activeFlag;
	logic [clockDisplayPkg::fieldWidth-1:0] cursor;

	vgaTiming timing (
		.CLK(CLK),
		.RESET(RESET),
		.posX(posX),
		.posY(posY),
		.hSync(rawHSync),
		.vSync(rawVSync),
		.blankStart(blankStart)
	);

	displayRegisterFile registers (
		.CLK(CLK),
		.RESET(RESET),
		.wrEnable(wrEnable),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	// Per-frame loader
	digitPointerBank pointers (
		.CLK(CLK),
		.RESET(RESET),
		.blankStart(blankStart),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.digitCodes(digitCodes),
		.ringFlag(ringFlag),
		.activeFlag(activeFlag),
		.cursor(cursor)
	);

	glyphAddressGenerator glyphs (
		.CLK(CLK),
		.RESET(RESET),
		.posX(posX),
		.posY(posY),
		.hSyncIn(rawHSync),
		.vSyncIn(rawVSync),
		.digitCodes(digitCodes),
		.ringFlag(ringFlag),
		.activeFlag(activeFlag),
		.cursor(cursor),
		.romSelect(romSelect),
		.romAddr(romAddr),
		.hSync(hSync),
		.vSync(vSync)
	);

endmodule

// ==== src/clockDisplayPkg.sv ====
package clockDisplayPkg;

	////////////////////////////////////////
	// VGA timing for 640x480
	////////////////////////////////////////

	// Horizontal, in pixel clocks
	localparam int hActive = 640;
	localparam int hTotal = 800;
	localparam int hSyncStart = 656;
	localparam int hSyncEnd = 752;

	// Vertical, in lines
	localparam int vActive = 480;
	localparam int vTotal = 525;
	localparam int vSyncStart = 490;
	localparam int vSyncEnd = 492;

	////////////////////////////////////////
	// Screen layout
	////////////////////////////////////////

	// Row stride of the background frame ROM
	localparam int frameWidth = 640;

	localparam int digitWidth = 40;
	localparam int digitHeight = 60;
	// Bottom rows of a box blanked under the cursor
	localparam int cursorBand = 5;

	localparam int indicatorWidth = 100;
	localparam int indicatorHeight = 18;
	// Glyph rows per indicator state
	localparam int indicatorStride = 20;

	localparam int dateRowY = 130;
	localparam int timeRowY = 288;
	localparam int indicatorRowY = 370;

	localparam int digitCount = 18;
	// First boxes of the table sit on the date row
	localparam int dateBoxCount = 6;

	// Box left edges, tens then units per pair
	localparam int digitX [digitCount] = '{
		132, 174, 232, 274, 416, 458,
		38, 80, 128, 170, 218, 260,
		339, 381, 429, 471, 519, 561
	};

	// Field address shown by each box
	localparam int digitField [digitCount] = '{
		4, 4, 5, 5, 6, 6,
		3, 3, 2, 2, 1, 1,
		9, 9, 8, 8, 7, 7
	};

	localparam int activeX = 338;
	localparam int ringX = 500;

	////////////////////////////////////////
	// Register file fields
	////////////////////////////////////////

	localparam int fieldCount = 12;
	localparam int fieldAddrWidth = 4;
	localparam int fieldWidth = 8;

	localparam int ringField = 10;
	localparam int activeField = 11;
	localparam int cursorField = 12;

	// ROM chip selects
	localparam logic [1:0] romBackground = 2'b00;
	localparam logic [1:0] romDigits = 2'b01;
	localparam logic [1:0] romIndicator = 2'b11;

	// One field byte, read as a number or as a flag
	typedef union packed {
		struct packed {
			logic unused;
			logic [6:0] value;
		} numberView;
		struct packed {
			logic [6:0] reserved;
			logic flag;
		} flagView;
	} fieldWord;

endpackage

// ==== src/digitPointerBank.sv ====
module digitPointerBank (
	input logic CLK,
	input logic RESET,
	input logic blankStart,
	output logic [clockDisplayPkg::fieldAddrWidth-1:0] rdAddr,
	input logic [clockDisplayPkg::fieldWidth-1:0] rdData,
	output logic [clockDisplayPkg::digitCount-1:0][3:0] digitCodes,
	output logic ringFlag,
	output logic activeFlag,
	output logic [clockDisplayPkg::fieldWidth-1:0] cursor
);

	clockDisplayPkg::fieldWord word;
	// Field that the word on rdData belongs to, zero when idle
	logic [clockDisplayPkg::fieldAddrWidth-1:0] dataAddr;
	logic [3:0] tens;
	logic [3:0] units;

	assign word = rdData;

	bcdConverter bcd (
		.value(word.numberView.value),
		.tens(tens),
		.units(units)
	);

	////////////////////////////////////////
	// Address stage
	////////////////////////////////////////

	// Walks fields 1 to 12 once per frame, zero means idle
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			rdAddr <= '0;
			dataAddr <= '0;
		end
		else
		begin
			dataAddr <= rdAddr;
			if (blankStart)
				rdAddr <= 4'd1;
			else if (rdAddr != '0 && rdAddr < 4'(clockDisplayPkg::fieldCount))
				rdAddr <= rdAddr + 4'd1;
			else
				rdAddr <= '0;
		end
	end

	////////////////////////////////////////
	// Data stage
	////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			digitCodes <= '0;
			ringFlag <= 1'b0;
			activeFlag <= 1'b0;
			cursor <= '0;
		end
		else
		begin
			// Even boxes hold tens, odd boxes hold units
			for (int b = 0; b < clockDisplayPkg::digitCount; b++)
			begin
				if (dataAddr == 4'(clockDisplayPkg::digitField[b]))
					digitCodes[b] <= (b % 2 == 0) ? tens : units;
			end

			if (dataAddr == 4'(clockDisplayPkg::ringField))
				ringFlag <= word.flagView.flag;
			if (dataAddr == 4'(clockDisplayPkg::activeField))
				activeFlag <= word.flagView.flag;
			// Cursor is kept as the raw byte
			if (dataAddr == 4'(clockDisplayPkg::cursorField))
				cursor <= rdData;
		end
	end

endmodule

// ==== src/displayRegisterFile.sv ====
module displayRegisterFile (
	input logic CLK,
	input logic RESET,
	input logic wrEnable,
	input logic [clockDisplayPkg::fieldAddrWidth-1:0] wrAddr,
	input logic [clockDisplayPkg::fieldWidth-1:0] wrData,
	input logic [clockDisplayPkg::fieldAddrWidth-1:0] rdAddr,
	output logic [clockDisplayPkg::fieldWidth-1:0] rdData
);

	logic [clockDisplayPkg::fieldWidth-1:0] fields [1:clockDisplayPkg::fieldCount];
	logic wrValid;
	logic rdValid;

	// Address 0 and anything above the last field are holes
	assign wrValid = wrEnable && (wrAddr != '0)
		&& (wrAddr <= 4'(clockDisplayPkg::fieldCount));
	assign rdValid = (rdAddr != '0) && (rdAddr <= 4'(clockDisplayPkg::fieldCount));

	// Host write port
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			for (int i = 1; i <= clockDisplayPkg::fieldCount; i++)
				fields[i] <= '0;
		end
		else if (wrValid)
		begin
			fields[wrAddr] <= wrData;
		end
	end

	// Registered read, one cycle behind rdAddr
	always_ff @(posedge CLK)
	begin
		if (rdValid)
			rdData <= fields[rdAddr];
		else
			rdData <= '0;
	end

endmodule

// ==== src/glyphAddressGenerator.sv ====
module glyphAddressGenerator (
	input logic CLK,
	input logic RESET,
	input logic [9:0] posX,
	input logic [9:0] posY,
	input logic hSyncIn,
	input logic vSyncIn,
	input logic [clockDisplayPkg::digitCount-1:0][3:0] digitCodes,
	input logic ringFlag,
	input logic activeFlag,
	input logic [clockDisplayPkg::fieldWidth-1:0] cursor,
	output logic [1:0] romSelect,
	output logic [18:0] romAddr,
	output logic hSync,
	output logic vSync
);

	logic inDateRow;
	logic inTimeRow;
	logic inIndicatorRow;
	logic [9:0] rowTop;
	logic [9:0] rowOffset;
	logic [9:0] indicatorOffset;
	logic inCursorBand;
	logic [1:0] nextSelect;
	logic [18:0] nextAddr;

	////////////////////////////////////////
	// Row bands with exclusive bottom edges
	////////////////////////////////////////

	assign inDateRow = posY >= 10'(clockDisplayPkg::dateRowY)
		&& posY < 10'(clockDisplayPkg::dateRowY + clockDisplayPkg::digitHeight);
	assign inTimeRow = posY >= 10'(clockDisplayPkg::timeRowY)
		&& posY < 10'(clockDisplayPkg::timeRowY + clockDisplayPkg::digitHeight);
	assign inIndicatorRow = posY >= 10'(clockDisplayPkg::indicatorRowY)
		&& posY < 10'(clockDisplayPkg::indicatorRowY + clockDisplayPkg::indicatorHeight);

	assign rowTop = inDateRow ? 10'(clockDisplayPkg::dateRowY)
		: 10'(clockDisplayPkg::timeRowY);
	assign rowOffset = posY - rowTop;
	assign indicatorOffset = posY - 10'(clockDisplayPkg::indicatorRowY);

	// Rows hidden under the cursor underline
	assign inCursorBand = rowOffset
		>= 10'(clockDisplayPkg::digitHeight - clockDisplayPkg::cursorBand);

	////////////////////////////////////////
	// Box hit tests
	////////////////////////////////////////

	always_comb
	begin
		// Background frame by default and during blanking
		nextSelect = clockDisplayPkg::romBackground;
		nextAddr = 19'(posX) + 19'(clockDisplayPkg::frameWidth) * 19'(posY);

		if (inDateRow || inTimeRow)
		begin
			for (int b = 0; b < clockDisplayPkg::digitCount; b++)
			begin
				// Only boxes on the current row band
				if (((b < clockDisplayPkg::dateBoxCount) == inDateRow)
					&& posX >= 10'(clockDisplayPkg::digitX[b])
					&& posX < 10'(clockDisplayPkg::digitX[b] + clockDisplayPkg::digitWidth)
					&& !(cursor == 8'(clockDisplayPkg::digitField[b]) && inCursorBand))
				begin
					nextSelect = clockDisplayPkg::romDigits;
					nextAddr = 19'(posX - 10'(clockDisplayPkg::digitX[b]))
						+ 19'(clockDisplayPkg::digitWidth) * (19'(rowOffset)
						+ 19'(digitCodes[b]) * 19'(clockDisplayPkg::digitHeight));
				end
			end
		end
		else if (inIndicatorRow)
		begin
			if (posX >= 10'(clockDisplayPkg::activeX)
				&& posX < 10'(clockDisplayPkg::activeX + clockDisplayPkg::indicatorWidth))
			begin
				nextSelect = clockDisplayPkg::romIndicator;
				nextAddr = 19'(posX - 10'(clockDisplayPkg::activeX))
					+ 19'(clockDisplayPkg::indicatorWidth) * (19'(indicatorOffset)
					+ (activeFlag ? 19'(clockDisplayPkg::indicatorStride) : 19'd0));
			end
			else if (posX >= 10'(clockDisplayPkg::ringX)
				&& posX < 10'(clockDisplayPkg::ringX + clockDisplayPkg::indicatorWidth))
			begin
				nextSelect = clockDisplayPkg::romIndicator;
				nextAddr = 19'(posX - 10'(clockDisplayPkg::ringX))
					+ 19'(clockDisplayPkg::indicatorWidth) * (19'(indicatorOffset)
					+ (ringFlag ? 19'(clockDisplayPkg::indicatorStride) : 19'd0));
			end
		end
	end

	// Output stage with syncs delayed to line up with romAddr
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			romSelect <= clockDisplayPkg::romBackground;
			hSync <= 1'b1;
			vSync <= 1'b1;
		end
		else
		begin
			romSelect <= nextSelect;
			hSync <= hSyncIn;
			vSync <= vSyncIn;
		end
	end

	// ROM address of the pixel one cycle back
	always_ff @(posedge CLK)
	begin
		romAddr <= nextAddr;
	end

endmodule

// ==== src/vgaTiming.sv ====
module vgaTiming (
	input logic CLK,
	input logic RESET,
	output logic [9:0] posX,
	output logic [9:0] posY,
	output logic hSync,
	output logic vSync,
	output logic blankStart
);

	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (posX == 10'(clockDisplayPkg::hTotal - 1));
	assign frameEnd = (posY == 10'(clockDisplayPkg::vTotal - 1));

	// Pixel and line counters
	always_ff @(posedge CLK)
	begin
		if (RESET)
		begin
			posX <= '0;
			posY <= '0;
		end
		else if (lineEnd)
		begin
			posX <= '0;
			if (frameEnd)
				posY <= '0;
			else
				posY <= posY + 10'd1;
		end
		else
		begin
			posX <= posX + 10'd1;
		end
	end

	// Active low pulses, registered later in the generator
	assign hSync = !(posX >= 10'(clockDisplayPkg::hSyncStart)
		&& posX < 10'(clockDisplayPkg::hSyncEnd));
	assign vSync = !(posY >= 10'(clockDisplayPkg::vSyncStart)
		&& posY < 10'(clockDisplayPkg::vSyncEnd));

	// First pixel of the first blank line
	assign blankStart = (posX == 10'd0) && (posY == 10'(clockDisplayPkg::vActive));

endmodule

// ==== verif/clockDisplayChk.sv ====
module clockDisplayChk (
	input logic CLK,
	input logic RESET,
	input logic [1:0] romSelect,
	input logic hSync,
	input logic vSync
);

	// Length of the hSync pulse seen so far
	int lowCount;

	always_ff @(posedge CLK)
	begin
		if (RESET || hSync)
			lowCount <= 0;
		else
			lowCount <= lowCount + 1;
	end

	// Code 10 has no ROM behind it
	noUnusedSelect: assert property (@(posedge CLK) disable iff (RESET)
		romSelect != 2'b10)
	else
		$error("romSelect took the unused code %b", romSelect);

	resetOutputs: assert property (@(posedge CLK)
		RESET |=> romSelect == clockDisplayPkg::romBackground && hSync && vSync)
	else
		$error("outputs not at their reset values after RESET");

	hSyncWidth: assert property (@(posedge CLK) disable iff (RESET)
		$rose(hSync) |-> lowCount == clockDisplayPkg::hSyncEnd - clockDisplayPkg::hSyncStart)
	else
		$error("hSync pulse lasted %0d cycles", lowCount);

endmodule

bind clockDisplay clockDisplayChk chk (
	.CLK(CLK),
	.RESET(RESET),
	.romSelect(romSelect),
	.hSync(hSync),
	.vSync(vSync)
);

// ==== verif/clockDisplayTb.sv ====
module clockDisplayTb;

	logic CLK = 1'b0;
	logic RESET;
	logic wrEnable;
	logic [3:0] wrAddr;
	logic [7:0] wrData;
	logic [1:0] romSelect;
	logic [18:0] romAddr;
	logic hSync;
	logic vSync;

	// Pixel that the outputs describe
	int outX;
	int outY;
	logic tracking = 1'b0;

	logic [7:0] fieldModel [1:12];
	// Field values as the last frame load saw them
	logic [7:0] shownField [1:12];
	logic [15:0] lfsrState = 16'd90;
	int checkErrors = 0;
	int timeoutErrors = 0;
	logic timedOut = 1'b0;

	clockDisplay uut (
		.CLK(CLK),
		.RESET(RESET),
		.wrEnable(wrEnable),
		.wrAddr(wrAddr),
		.wrData(wrData),
		.romSelect(romSelect),
		.romAddr(romAddr),
		.hSync(hSync),
		.vSync(vSync)
	);

	initial
	begin
		forever #2 CLK = ~CLK;
	end

	// One cycle of latency so (0,0) shows after the first free edge
	always @(posedge CLK)
	begin
		if (RESET)
			tracking <= 1'b0;
		else if (!tracking)
		begin
			tracking <= 1'b1;
			outX <= 0;
			outY <= 0;
		end
		else if (outX == clockDisplayPkg::hTotal - 1)
		begin
			outX <= 0;
			outY <= (outY == clockDisplayPkg::vTotal - 1) ? 0 : outY + 1;
		end
		else
			outX <= outX + 1;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBits(input int count, output int bits);
		bits = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			bits = (bits << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic writeField(input int addr, input logic [7:0] data);
		wrEnable = 1'b1;
		wrAddr = 4'(addr);
		wrData = data;
		@(negedge CLK);
		wrEnable = 1'b0;
		if (addr >= 1 && addr <= clockDisplayPkg::fieldCount)
			fieldModel[addr] = data;
	endtask

	task automatic waitPixel(input int x, input int y);
		int cycles;
		cycles = 0;
		if (!timedOut)
		begin
			@(negedge CLK);
			while (!(tracking && outX == x && outY == y)
				&& cycles < clockDisplayPkg::hTotal * clockDisplayPkg::vTotal + 16)
			begin
				@(negedge CLK);
				cycles++;
			end
			if (!(tracking && outX == x && outY == y))
			begin
				$display("Timeout: pixel (%0d,%0d) never reached the outputs", x, y);
				timeoutErrors++;
				timedOut = 1'b1;
			end
		end
	endtask

	// Past the loader burst so the coming frame shows the written fields
	task automatic nextFrame();
		waitPixel(0, clockDisplayPkg::vActive + 1);
		for (int f = 1; f <= clockDisplayPkg::fieldCount; f++)
			shownField[f] = fieldModel[f];
	endtask

	////////////////////////////////////////
	// Expected values
	////////////////////////////////////////

	function automatic int backgroundAddr(input int x, input int y);
		return x + clockDisplayPkg::frameWidth * y;
	endfunction

	task automatic compareOutputs(input int x, input int y, input logic [1:0] expSel,
		input int expAddr);
		if (!timedOut)
		begin
			if (romSelect != expSel)
			begin
				$display("CHECK FAILED romSelect at (%0d,%0d): got %h, expected %h",
					x, y, romSelect, expSel);
				checkErrors++;
			end
			if (romAddr != 19'(expAddr))
			begin
				$display("CHECK FAILED romAddr at (%0d,%0d): got %h, expected %h",
					x, y, romAddr, 19'(expAddr));
				checkErrors++;
			end
		end
	endtask

	task automatic expectPixel(input int x, input int y, input logic [1:0] sel, input int addr);
		waitPixel(x, y);
		compareOutputs(x, y, sel, addr);
	endtask

	task automatic expectBackground(input int x, input int y);
		expectPixel(x, y, clockDisplayPkg::romBackground, backgroundAddr(x, y));
	endtask

	task automatic expectDigit(input int b, input int digit, input int dx, input int dy);
		int x0;
		int y0;
		x0 = clockDisplayPkg::digitX[b];
		y0 = (b < clockDisplayPkg::dateBoxCount) ? clockDisplayPkg::dateRowY
			: clockDisplayPkg::timeRowY;
		expectPixel(x0 + dx, y0 + dy, clockDisplayPkg::romDigits,
			dx + clockDisplayPkg::digitWidth * (dy + digit * clockDisplayPkg::digitHeight));
	endtask

	// Digit from the shown field or background under the cursor band
	task automatic expectBox(input int b, input int dx, input int dy);
		int field;
		int value;
		int digit;
		int y0;
		field = clockDisplayPkg::digitField[b];
		value = int'(shownField[field][6:0]);
		digit = (b % 2 == 0) ? (value / 10) % 10 : value % 10;
		y0 = (b < clockDisplayPkg::dateBoxCount) ? clockDisplayPkg::dateRowY
			: clockDisplayPkg::timeRowY;
		if (int'(shownField[clockDisplayPkg::cursorField]) == field
			&& dy >= clockDisplayPkg::digitHeight - clockDisplayPkg::cursorBand)
			expectBackground(clockDisplayPkg::digitX[b] + dx, y0 + dy);
		else
			expectDigit(b, digit, dx, dy);
	endtask

	task automatic expectIndicator(input int x0, input int field, input int dx, input int dy);
		int flag;
		flag = int'(shownField[field][0]);
		expectPixel(x0 + dx, clockDisplayPkg::indicatorRowY + dy, clockDisplayPkg::romIndicator,
			dx + clockDisplayPkg::indicatorWidth * (dy + flag * clockDisplayPkg::indicatorStride));
	endtask

	task automatic expectSync(input int x, input int y);
		logic expH;
		logic expV;
		expH = !(x >= clockDisplayPkg::hSyncStart && x < clockDisplayPkg::hSyncEnd);
		expV = !(y >= clockDisplayPkg::vSyncStart && y < clockDisplayPkg::vSyncEnd);
		waitPixel(x, y);
		if (!timedOut && hSync != expH)
		begin
			$display("CHECK FAILED hSync at (%0d,%0d): got %h, expected %h", x, y, hSync, expH);
			checkErrors++;
		end
		if (!timedOut && vSync != expV)
		begin
			$display("CHECK FAILED vSync at (%0d,%0d): got %h, expected %h", x, y, vSync, expV);
			checkErrors++;
		end
	endtask

	////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////

	task automatic resetState();
		compareOutputs(0, 0, clockDisplayPkg::romBackground, 0);
		if (hSync != 1'b1)
		begin
			$display("CHECK FAILED hSync in reset: got %h, expected 1", hSync);
			checkErrors++;
		end
		if (vSync != 1'b1)
		begin
			$display("CHECK FAILED vSync in reset: got %h, expected 1", vSync);
			checkErrors++;
		end
		RESET = 1'b0;
		for (int x = 0; x < 6; x++)
			expectBackground(x, 0);
		expectBackground(639, 0);
		expectBackground(700, 0);
		expectBackground(3, 1);
	endtask

	task automatic digitAddressing();
		int r;
		for (int f = 1; f <= 9; f++)
		begin
			randomBits(7, r);
			writeField(f, 8'(r % 100));
		end
		nextFrame();
		// Box order is already raster order
		for (int b = 0; b < clockDisplayPkg::digitCount; b++)
			expectBox(b, 11 + b, 17);
	endtask

	task automatic indicatorFlags();
		int r;
		for (int combo = 0; combo < 4; combo++)
		begin
			randomBits(7, r);
			writeField(clockDisplayPkg::ringField, {7'(r), combo[0]});
			randomBits(7, r);
			writeField(clockDisplayPkg::activeField, {7'(r), combo[1]});
			nextFrame();
			expectIndicator(clockDisplayPkg::activeX, clockDisplayPkg::activeField, 7, 5);
			expectBackground(clockDisplayPkg::activeX + clockDisplayPkg::indicatorWidth,
				clockDisplayPkg::indicatorRowY + 5);
			expectIndicator(clockDisplayPkg::ringX, clockDisplayPkg::ringField, 93, 17);
			expectBackground(clockDisplayPkg::ringX + clockDisplayPkg::indicatorWidth,
				clockDisplayPkg::indicatorRowY + 17);
			expectBackground(clockDisplayPkg::ringX + 7,
				clockDisplayPkg::indicatorRowY + clockDisplayPkg::indicatorHeight);
		end
	endtask

	task automatic cursorMasking();
		// Cursor on the clock minutes
		writeField(clockDisplayPkg::cursorField, 8'd2);
		nextFrame();
		expectBox(0, 5, 58);
		expectBox(8, 5, 54);
		expectBox(8, 5, 55);
		expectBox(9, 30, 57);
		expectBox(10, 3, 57);
		expectBox(7, 20, 59);
		expectBox(9, 39, 59);
		// The top bit stops a whole byte match
		writeField(clockDisplayPkg::cursorField, 8'h82);
		nextFrame();
		expectBox(8, 5, 57);
		writeField(clockDisplayPkg::cursorField, 8'd0);
	endtask

	task automatic frameUpdate();
		int oldDay;
		nextFrame();
		oldDay = int'(fieldModel[4]);
		waitPixel(0, clockDisplayPkg::dateRowY - 10);
		writeField(4, 8'((oldDay + 37) % 100));
		writeField(3, 8'd123);
		// Current frame keeps the old digits
		expectBox(0, 9, 20);
		expectBox(1, 9, 20);
		expectBox(6, 9, 20);
		expectBox(7, 9, 20);
		nextFrame();
		expectBox(0, 9, 20);
		expectBox(1, 9, 20);
		expectDigit(6, 2, 9, 20);
		expectDigit(7, 3, 9, 20);
	endtask

	task automatic syncPulses();
		for (int x = clockDisplayPkg::hSyncStart - 2; x <= clockDisplayPkg::hSyncEnd + 1; x++)
			expectSync(x, 100);
		expectSync(clockDisplayPkg::hTotal - 1, clockDisplayPkg::vSyncStart - 1);
		expectSync(0, clockDisplayPkg::vSyncStart);
		expectSync(clockDisplayPkg::hTotal - 1, clockDisplayPkg::vSyncEnd - 1);
		expectSync(0, clockDisplayPkg::vSyncEnd);
	endtask

	initial
	begin
		RESET = 1'b1;
		wrEnable = 1'b0;
		wrAddr = 4'd0;
		wrData = 8'd0;
		for (int f = 1; f <= clockDisplayPkg::fieldCount; f++)
		begin
			fieldModel[f] = 8'd0;
			shownField[f] = 8'd0;
		end
		repeat (8) @(negedge CLK);

		resetState();
		digitAddressing();
		indicatorFlags();
		cursorMasking();
		frameUpdate();
		syncPulses();

		$display("Errors: %0d mismatches, %0d timeouts", checkErrors, timeoutErrors);
		if (checkErrors == 0 && timeoutErrors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
